/* tb.f */
spatz_decoder_pkg.sv
spatz_lsu_decoder.sv
spatz_vfu_decoder.sv
spatz_cfg_decoder.sv
spatz_decoder.sv
spatz_decoder_chk.sv
tb_spatz_decoder.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_spatz_decoder
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* tb_spatz_decoder.sv */
`timescale 1ns/1ps

module tb_spatz_decoder;
  import spatz_decoder_pkg::*;

  // Requests per test summed for the cycle limit
  localparam int N_REQ = 15 + 45 + 9 + 43 + 13 + 60;
  localparam int LIMIT = N_REQ + 20;

  logic         clk_i = 1'b0;
  logic         reset_i;
  decoder_req_t decoder_req_i;
  logic         decoder_req_valid_i;
  decoder_rsp_t decoder_rsp_o;
  logic         decoder_rsp_valid_o;

  integer       seed = 46;
  int           errors = 0;
  int           tests_pass = 0;
  int           tests_fail = 0;
  int           err_start = 0;
  int           cycles = 0;
  logic         exp_valid_q[$];
  decoder_rsp_t exp_rsp_q[$];

  logic [5:0]  f6_opi [13] = '{F6_VADD, F6_VSUB, F6_VRSUB, F6_VAND, F6_VOR, F6_VXOR, F6_VSLL,
                               F6_VSRL, F6_VSRA, F6_VMIN, F6_VMINU, F6_VMAX, F6_VMAXU};
  logic [11:0] csrs [7] = '{CSR_VSTART, CSR_VL, CSR_VTYPE, CSR_VLENB, CSR_VXSAT, CSR_VXRM,
                            CSR_VCSR};

  spatz_decoder spatz_decoder_inst (.*);

  always #2 clk_i = ~clk_i;

  function automatic instr_t vop_instr(logic [5:0] f6, logic [2:0] f3, logic [4:0] fld,
                                       logic vm);
    return {f6, vm, 5'd9, fld, f3, 5'd3, OPC_OP_V};
  endfunction

  function automatic instr_t mem_instr(logic is_ld, logic [1:0] mop, logic [2:0] width);
    return {3'b000, 1'b0, mop, 1'b1, 5'd7, 5'd10, width, 5'd4,
            is_ld ? OPC_LOAD_FP : OPC_STORE_FP};
  endfunction

  function automatic instr_t csr_instr(logic [11:0] addr, logic [2:0] f3, logic [4:0] fld,
                                       logic [4:0] rd);
    return {addr, fld, f3, rd, OPC_SYSTEM};
  endfunction

  // Expected response built from the decode rules
  function automatic decoder_rsp_t decode_ref(decoder_req_t rq, logic valid);
    spatz_req_t   r;
    decoder_rsp_t rsp;
    logic         ill;
    logic [6:0]   opc;
    logic [2:0]   f3;
    logic [5:0]   f6;
    logic [4:0]   fld;
    logic [4:0]   rd;
    logic         vv;
    logic         vi;
    logic         opm;
    logic         uimm;
    logic [7:0]   vt;
    logic         csr_known;
    r    = '0;
    ill  = 1'b0;
    uimm = 1'b0;
    opc  = rq.instr[6:0];
    f3   = rq.instr[14:12];
    f6   = rq.instr[31:26];
    fld  = rq.instr[19:15];
    rd   = rq.instr[11:7];
    vv   = (f3 == 3'b000) || (f3 == 3'b010);
    vi   = (f3 == 3'b011);
    opm  = (f3 == 3'b010) || (f3 == 3'b110);
    if (opc == OPC_LOAD_FP || opc == OPC_STORE_FP) begin
      r.ex_unit        = LSU;
      r.vd             = rd;
      r.use_vd         = 1'b1;
      r.vd_is_src      = (opc == OPC_STORE_FP);
      r.op_mem.vm      = rq.instr[25];
      r.op_mem.is_load = (opc == OPC_LOAD_FP);
      r.rs1            = rq.rs1;
      case ({rq.instr[28], f3})
        4'b0000: r.vtype.vsew = EW_8;
        4'b0101: r.vtype.vsew = EW_16;
        4'b0110: r.vtype.vsew = EW_32;
        default: ill = 1'b1;
      endcase
      if (rq.instr[27:26] == MOP_UNIT) begin
        r.op = r.op_mem.is_load ? VLE : VSE;
      end else if (rq.instr[27:26] == MOP_STRIDED) begin
        r.op  = r.op_mem.is_load ? VLSE : VSSE;
        r.rs2 = rq.rs2;
        ill   = ill | ~rq.rs2_valid;
      end else begin
        ill = 1'b1;
      end
      ill = ill | ~rq.rs1_valid;
      r.op_cfg.reset_vstart = ~ill;
    end else if (opc == OPC_OP_V && f3 != 3'b111) begin
      r.ex_unit     = VFU;
      r.vd          = rd;
      r.use_vd      = 1'b1;
      r.vs2         = rq.instr[24:20];
      r.use_vs2     = 1'b1;
      r.op_arith.vm = rq.instr[25];
      r.op_sld.vm   = rq.instr[25];
      if (vv) begin
        r.use_vs1 = 1'b1;
        r.vs1     = fld;
      end else if (vi) begin
        r.rs1 = {{27{fld[4]}}, fld};
      end else if (f3 == 3'b100 || f3 == 3'b110) begin
        r.rs1 = rq.rs1;
        ill   = ~rq.rs1_valid;
      end else begin
        ill = 1'b1;
      end
      if (opm) begin
        if (f6 == F6_VMUL) begin
          r.op = VMUL;
        end else if (f6 == F6_VMACC) begin
          r.op        = VMACC;
          r.vd_is_src = 1'b1;
        end else if (f6 == F6_VSLIDEUP || f6 == F6_VSLIDEDOWN) begin
          r.op            = (f6 == F6_VSLIDEUP) ? VSLIDEUP : VSLIDEDOWN;
          r.ex_unit       = SLD;
          r.op_sld.insert = 1'b1;
          ill             = ill | vv;
        end else begin
          ill = 1'b1;
        end
      end else begin
        case (f6)
          F6_VADD:  r.op = VADD;
          F6_VSUB:  r.op = VSUB;
          F6_VRSUB: r.op = VRSUB;
          F6_VAND:  r.op = VAND;
          F6_VOR:   r.op = VOR;
          F6_VXOR:  r.op = VXOR;
          F6_VMIN:  r.op = VMIN;
          F6_VMINU: r.op = VMINU;
          F6_VMAX:  r.op = VMAX;
          F6_VMAXU: r.op = VMAXU;
          F6_VSLL: begin
            r.op = VSLL;
            uimm = 1'b1;
          end
          F6_VSRL: begin
            r.op = VSRL;
            uimm = 1'b1;
          end
          F6_VSRA: begin
            r.op = VSRA;
            uimm = 1'b1;
          end
          F6_VMV: begin
            r.op            = VSLIDEUP;
            r.ex_unit       = SLD;
            r.op_sld.vmv    = 1'b1;
            r.op_sld.insert = ~vv;
            r.vs2           = vv ? fld : 5'd0;
            r.use_vs2       = ~vi;
            ill             = ill | ~rq.instr[25];
          end
          F6_VSLIDEUP, F6_VSLIDEDOWN: begin
            r.op      = (f6 == F6_VSLIDEUP) ? VSLIDEUP : VSLIDEDOWN;
            r.ex_unit = SLD;
            uimm      = 1'b1;
            ill       = ill | vv;
          end
          default: ill = 1'b1;
        endcase
        if (vi && f6 inside {F6_VSUB, F6_VMIN, F6_VMINU, F6_VMAX, F6_VMAXU}) begin
          ill = 1'b1;
        end
        if (vv && f6 == F6_VRSUB) begin
          ill = 1'b1;
        end
        if (vi && uimm) begin
          r.rs1 = {27'd0, fld};
        end
      end
      r.op_cfg.reset_vstart = ~ill;
    end else if (opc == OPC_SYSTEM || opc == OPC_OP_V) begin
      r.ex_unit = CON;
      r.rd      = rd;
      r.use_rd  = 1'b1;
      if (opc == OPC_SYSTEM) begin
        r.op       = VCSR;
        r.csr_addr = rq.instr[31:20];
        r.rs1      = rq.instr[14] ? {27'd0, fld} : rq.rs1;
        ill        = ~rq.instr[14] & ~rq.rs1_valid;
        csr_known  = 1'b0;
        foreach (csrs[j]) begin
          if (csrs[j] == r.csr_addr) begin
            csr_known = 1'b1;
          end
        end
        if (!csr_known) begin
          ill = 1'b1;
        end
        case (f3[1:0])
          CSR_F3_RW: begin
            if (r.csr_addr == CSR_VSTART) begin
              r.use_rd              = (rd != 5'd0);
              r.op_cfg.write_vstart = 1'b1;
            end
          end
          CSR_F3_RS: r.op_cfg.set_vstart = (r.csr_addr == CSR_VSTART) && (fld != 5'd0);
          CSR_F3_RC: r.op_cfg.clear_vstart = (r.csr_addr == CSR_VSTART) && (fld != 5'd0);
          default:   ill = 1'b1;
        endcase
      end else begin
        r.op = VCFG;
        vt   = rq.instr[27:20];
        if (!rq.instr[31]) begin
          r.rs1 = rq.rs1;
          ill   = ~rq.rs1_valid;
        end else if (rq.instr[31:30] == 2'b11) begin
          r.rs1 = {27'd0, fld};
        end else if (rq.instr[31:25] == 7'b1000000) begin
          vt    = rq.rs2[7:0];
          r.rs1 = rq.rs1;
          ill   = ~rq.rs1_valid | ~rq.rs2_valid;
        end else begin
          ill = 1'b1;
        end
        r.vtype.vsew = vew_e'(vt[4:3]);
        r.vtype.vlow = {vt[7:5], vt[2:0]};
        if (fld == 5'd0 && rd != 5'd0) begin
          r.rs1 = '1;
        end
        r.op_cfg.keep_vl      = (fld == 5'd0) && (rd == 5'd0);
        r.op_cfg.reset_vstart = ~ill;
      end
    end else begin
      ill = 1'b1;
    end
    r.xintf_id        = rq.xintf_id;
    rsp.spatz_req     = r;
    rsp.instr_illegal = valid & ill;
    return rsp;
  endfunction

  task automatic send_req(instr_t instr, logic rs1_ok, logic rs2_ok);
    decoder_req_i.instr     = instr;
    decoder_req_i.rs1       = $random(seed);
    decoder_req_i.rs2       = $random(seed);
    decoder_req_i.rs1_valid = rs1_ok;
    decoder_req_i.rs2_valid = rs2_ok;
    decoder_req_i.xintf_id  = 4'($random(seed));
    decoder_req_valid_i     = 1'b1;
    @(posedge clk_i);
    #1;
  endtask

  task automatic end_test(string name);
    decoder_req_valid_i = 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    #1;
    if (errors == err_start) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d mismatches", name, errors - err_start);
    end
    err_start = errors;
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected queue and comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!reset_i) begin
      exp_valid_q.push_back(decoder_req_valid_i);
      exp_rsp_q.push_back(decode_ref(decoder_req_i, decoder_req_valid_i));
    end
  end

  always @(negedge clk_i) begin
    logic         ev;
    decoder_rsp_t er;
    if (reset_i) begin
      assert (!decoder_rsp_valid_o) else begin
        $display("[ERROR] decoder_rsp_valid_o expected 0 actual %h", decoder_rsp_valid_o);
        errors++;
      end
    end else if (exp_valid_q.size() > 0) begin
      ev = exp_valid_q.pop_front();
      er = exp_rsp_q.pop_front();
      assert (decoder_rsp_valid_o === ev) else begin
        $display("[ERROR] decoder_rsp_valid_o expected %h actual %h", ev, decoder_rsp_valid_o);
        errors++;
      end
      if (ev) begin
        assert (decoder_rsp_o.instr_illegal === er.instr_illegal) else begin
          $display("[ERROR] instr_illegal expected %h actual %h", er.instr_illegal,
                   decoder_rsp_o.instr_illegal);
          errors++;
        end
        assert (decoder_rsp_o === er) else begin
          $display("[ERROR] decoder_rsp_o expected %h actual %h", er, decoder_rsp_o);
          errors++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i) begin
      cycles++;
    end
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [2:0] widths [3] = '{3'b000, 3'b101, 3'b110};
    logic [2:0] forms [3] = '{OPIVV, OPIVX, OPIVI};
    logic [4:0] fld;
    logic [4:0] rd;
    logic [11:0] top;
    reset_i             = 1'b1;
    decoder_req_i       = '0;
    decoder_req_valid_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    for (int w = 0; w < 3; w++) begin
      for (int m = 0; m < 2; m++) begin
        send_req(mem_instr(1'b1, m ? MOP_STRIDED : MOP_UNIT, widths[w]), 1'b1, 1'b1);
        send_req(mem_instr(1'b0, m ? MOP_STRIDED : MOP_UNIT, widths[w]), 1'b1, 1'b1);
      end
    end
    send_req(mem_instr(1'b1, MOP_UNIT, 3'b111), 1'b1, 1'b1);
    send_req(mem_instr(1'b0, MOP_UNIT, 3'b110), 1'b0, 1'b1);
    send_req(mem_instr(1'b1, MOP_STRIDED, 3'b101), 1'b1, 1'b0);
    end_test("load_store");

    for (int i = 0; i < 13; i++) begin
      for (int f = 0; f < 3; f++) begin
        fld = (forms[f] == OPIVI) ? 5'h16 : 5'($random(seed));
        send_req(vop_instr(f6_opi[i], forms[f], fld, 1'b1), 1'b1, 1'b1);
      end
    end
    send_req(vop_instr(F6_VMUL, OPMVV, 5'd2, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VMUL, OPMVX, 5'd2, 1'b0), 1'b1, 1'b1);
    send_req(vop_instr(F6_VMACC, OPMVV, 5'd5, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VMACC, OPMVX, 5'd5, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VADD, OPIVX, 5'd1, 1'b1), 1'b0, 1'b1);
    send_req(vop_instr(6'b111111, OPIVV, 5'd1, 1'b1), 1'b1, 1'b1);
    end_test("arith");

    for (int f = 0; f < 3; f++) begin
      send_req(vop_instr(F6_VMV, forms[f], 5'h13, 1'b1), 1'b1, 1'b1);
    end
    send_req(vop_instr(F6_VSLIDEUP, OPIVX, 5'd1, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VSLIDEUP, OPIVI, 5'h1C, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VSLIDEDOWN, OPIVX, 5'd1, 1'b0), 1'b1, 1'b1);
    send_req(vop_instr(F6_VSLIDEDOWN, OPIVI, 5'h11, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VSLIDEUP, OPMVX, 5'd1, 1'b1), 1'b1, 1'b1);
    send_req(vop_instr(F6_VSLIDEDOWN, OPMVX, 5'd1, 1'b1), 1'b1, 1'b1);
    end_test("move_slide");

    for (int c = 0; c < 7; c++) begin
      for (int f = 1; f < 4; f++) begin
        for (int imm = 0; imm < 2; imm++) begin
          rd  = imm ? 5'd0 : 5'($random(seed));
          // Set with a zero field is a plain read
          fld = (f == 2 && imm == 1) ? 5'd0 : 5'($random(seed));
          send_req(csr_instr(csrs[c], {imm[0], f[1:0]}, fld, rd), 1'b1, 1'b1);
        end
      end
    end
    send_req(csr_instr(12'h7C0, 3'b001, 5'd3, 5'd4), 1'b1, 1'b1);
    end_test("csr");

    for (int k = 0; k < 3; k++) begin
      for (int z = 0; z < 4; z++) begin
        fld = z[0] ? 5'd0 : 5'd6;
        rd  = z[1] ? 5'd0 : 5'd8;
        case (k)
          0:       top = {1'b0, 11'($random(seed))};
          1:       top = {2'b11, 10'($random(seed))};
          default: top = {7'b1000000, 5'd11};
        endcase
        send_req({top, fld, 3'b111, rd, OPC_OP_V}, 1'b1, 1'b1);
      end
    end
    send_req({25'h0ABCDE, 7'b1111111}, 1'b1, 1'b1);
    end_test("vsetvl");

    // Random stream with gaps in valid
    for (int n = 0; n < 60; n++) begin
      case ($unsigned($random(seed)) % 4)
        0: decoder_req_i.instr = vop_instr(f6_opi[$unsigned($random(seed)) % 13],
                                           3'($random(seed)), 5'($random(seed)), 1'b1);
        1: decoder_req_i.instr = mem_instr(1'($random(seed)), {1'($random(seed)), 1'b0},
                                           widths[$unsigned($random(seed)) % 3]);
        2: decoder_req_i.instr = csr_instr(csrs[$unsigned($random(seed)) % 7],
                                           3'($random(seed)), 5'($random(seed)), 5'd2);
        default: decoder_req_i.instr = $random(seed);
      endcase
      decoder_req_i.rs1       = $random(seed);
      decoder_req_i.rs2       = $random(seed);
      decoder_req_i.rs1_valid = ($unsigned($random(seed)) % 8) != 0;
      decoder_req_i.rs2_valid = ($unsigned($random(seed)) % 8) != 0;
      decoder_req_i.xintf_id  = 4'($random(seed));
      decoder_req_valid_i     = ($unsigned($random(seed)) % 4) != 0;
      @(posedge clk_i);
      #1;
    end
    end_test("random_stream");

    $display("passed %0d failed %0d mismatches %0d", tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* spatz_decoder_chk.sv */
`timescale 1ns/1ps

module spatz_decoder_chk (
  input logic                            clk_i,
  input logic                            reset_i,
  input logic                            decoder_req_valid_i,
  input spatz_decoder_pkg::decoder_rsp_t decoder_rsp_o,
  input logic                            decoder_rsp_valid_o
);

  rsp_idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !decoder_rsp_valid_o)
    else $error("response valid after reset");

  rsp_valid_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> decoder_rsp_valid_o == $past(decoder_req_valid_i))
    else $error("response valid does not follow request valid");

  illegal_keeps_vstart: assert property (@(posedge clk_i)
    decoder_rsp_o.instr_illegal |-> !decoder_rsp_o.spatz_req.op_cfg.reset_vstart)
    else $error("illegal response resets vstart");

endmodule

bind spatz_decoder spatz_decoder_chk chk_inst (.*);

/* spatz_decoder.sv */
`timescale 1ns/1ps

module spatz_decoder (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  spatz_decoder_pkg::decoder_req_t decoder_req_i,
  input  logic                            decoder_req_valid_i,
  output spatz_decoder_pkg::decoder_rsp_t decoder_rsp_o,
  output logic                            decoder_rsp_valid_o
);
  import spatz_decoder_pkg::*;

  typedef enum logic [1:0] {
    CLS_NONE,
    CLS_LSU,
    CLS_VFU,
    CLS_CFG
  } instr_class_e;

  logic [6:0]     opcode;
  opcodev_func3_e func3;
  instr_class_e   instr_class;
  spatz_req_t     lsu_req;
  spatz_req_t     vfu_req;
  spatz_req_t     cfg_req;
  spatz_req_t     sel_req;
  logic           lsu_illegal;
  logic           vfu_illegal;
  logic           cfg_illegal;
  logic           sel_illegal;
  decoder_rsp_t   rsp_d;
  decoder_rsp_t   rsp_q;
  logic           valid_q;

  assign opcode = decoder_req_i.instr[6:0];
  assign func3  = opcodev_func3_e'(decoder_req_i.instr[14:12]);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction class
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opcode)
      OPC_LOAD_FP, OPC_STORE_FP: instr_class = CLS_LSU;
      OPC_OP_V:                  instr_class = (func3 == OPCFG) ? CLS_CFG : CLS_VFU;
      OPC_SYSTEM:                instr_class = CLS_CFG;
      default:                   instr_class = CLS_NONE;
    endcase
  end

  spatz_lsu_decoder lsu_decoder_inst (
    .decoder_req_i (decoder_req_i),
    .lsu_req_o     (lsu_req),
    .illegal_o     (lsu_illegal)
  );

  spatz_vfu_decoder vfu_decoder_inst (
    .decoder_req_i (decoder_req_i),
    .vfu_req_o     (vfu_req),
    .illegal_o     (vfu_illegal)
  );

  spatz_cfg_decoder cfg_decoder_inst (
    .decoder_req_i (decoder_req_i),
    .cfg_req_o     (cfg_req),
    .illegal_o     (cfg_illegal)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result select and response register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_req     = '0;
    sel_illegal = 1'b1;
    case (instr_class)
      CLS_LSU: begin
        sel_req     = lsu_req;
        sel_illegal = lsu_illegal;
      end
      CLS_VFU: begin
        sel_req     = vfu_req;
        sel_illegal = vfu_illegal;
      end
      CLS_CFG: begin
        sel_req     = cfg_req;
        sel_illegal = cfg_illegal;
      end
      default: ;
    endcase
    // A legal vector op restarts at element zero
    if (instr_class == CLS_LSU || instr_class == CLS_VFU) begin
      sel_req.op_cfg.reset_vstart = ~sel_illegal;
    end
    sel_req.xintf_id = decoder_req_i.xintf_id;
  end

  assign rsp_d.spatz_req     = sel_req;
  assign rsp_d.instr_illegal = decoder_req_valid_i & sel_illegal;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      rsp_q   <= rsp_d;
      valid_q <= decoder_req_valid_i;
    end
  end

  assign decoder_rsp_o       = rsp_q;
  assign decoder_rsp_valid_o = valid_q;

endmodule

/* spatz_cfg_decoder.sv */
`timescale 1ns/1ps

module spatz_cfg_decoder (
  input  spatz_decoder_pkg::decoder_req_t decoder_req_i,
  output spatz_decoder_pkg::spatz_req_t   cfg_req_o,
  output logic                            illegal_o
);
  import spatz_decoder_pkg::*;

  logic [11:0] csr_addr;
  vreg_t       rd;
  vreg_t       rs1_field;
  logic        csr_is_imm;
  logic [7:0]  vtype_raw;

  assign csr_addr   = decoder_req_i.instr[31:20];
  assign rd         = decoder_req_i.instr[11:7];
  assign rs1_field  = decoder_req_i.instr[19:15];
  assign csr_is_imm = decoder_req_i.instr[14];

  always_comb begin
    cfg_req_o = '0;
    illegal_o = 1'b0;
    vtype_raw = '0;

    cfg_req_o.ex_unit = CON;
    cfg_req_o.rd      = rd;
    cfg_req_o.use_rd  = 1'b1;

    if (decoder_req_i.instr[6:0] == OPC_SYSTEM) begin
      cfg_req_o.op       = VCSR;
      cfg_req_o.csr_addr = csr_addr;
      cfg_req_o.rs1      = csr_is_imm ? elen_t'(rs1_field) : decoder_req_i.rs1;
      illegal_o          = ~csr_is_imm & ~decoder_req_i.rs1_valid;

      if (!(csr_addr inside {CSR_VSTART, CSR_VL, CSR_VTYPE, CSR_VLENB,
                             CSR_VXSAT, CSR_VXRM, CSR_VCSR})) begin
        illegal_o = 1'b1;
      end

      // Only vstart is written here, the rest go to the controller
      case (decoder_req_i.instr[13:12])
        CSR_F3_RW: begin
          if (csr_addr == CSR_VSTART) begin
            cfg_req_o.use_rd              = (rd != '0);
            cfg_req_o.op_cfg.write_vstart = 1'b1;
          end
        end
        CSR_F3_RS: cfg_req_o.op_cfg.set_vstart = (csr_addr == CSR_VSTART) && (rs1_field != '0);
        CSR_F3_RC: cfg_req_o.op_cfg.clear_vstart = (csr_addr == CSR_VSTART) && (rs1_field != '0);
        default:   illegal_o = 1'b1;
      endcase
    end else begin
      cfg_req_o.op = VCFG;
      vtype_raw    = decoder_req_i.instr[27:20];

      if (!decoder_req_i.instr[31]) begin
        // vsetvli
        cfg_req_o.rs1 = decoder_req_i.rs1;
        illegal_o     = ~decoder_req_i.rs1_valid;
      end else if (decoder_req_i.instr[31:30] == 2'b11) begin
        // vsetivli, AVL from the uimm
        cfg_req_o.rs1 = elen_t'(rs1_field);
      end else if (decoder_req_i.instr[31:25] == 7'b1000000) begin
        // vsetvl
        vtype_raw     = decoder_req_i.rs2[7:0];
        cfg_req_o.rs1 = decoder_req_i.rs1;
        illegal_o     = ~decoder_req_i.rs1_valid | ~decoder_req_i.rs2_valid;
      end else begin
        illegal_o = 1'b1;
      end

      cfg_req_o.vtype.vsew = vew_e'(vtype_raw[4:3]);
      cfg_req_o.vtype.vlow = {vtype_raw[7:5], vtype_raw[2:0]};

      // Request VLMAX
      if (rs1_field == '0 && rd != '0) begin
        cfg_req_o.rs1 = '1;
      end
      cfg_req_o.op_cfg.keep_vl      = (rs1_field == '0) && (rd == '0);
      cfg_req_o.op_cfg.reset_vstart = ~illegal_o;
    end
  end

endmodule

/* spatz_vfu_decoder.sv */
`timescale 1ns/1ps

module spatz_vfu_decoder (
  input  spatz_decoder_pkg::decoder_req_t decoder_req_i,
  output spatz_decoder_pkg::spatz_req_t   vfu_req_o,
  output logic                            illegal_o
);
  import spatz_decoder_pkg::*;

  opcodev_func3_e func3;
  logic [5:0]     funct6;
  vreg_t          op_field;
  logic           vm;
  logic           is_vv;
  logic           is_vi;
  logic           is_opm;
  elen_t          imm_sext;
  elen_t          imm_zext;
  logic           uimm;

  assign func3    = opcodev_func3_e'(decoder_req_i.instr[14:12]);
  assign funct6   = decoder_req_i.instr[31:26];
  assign op_field = decoder_req_i.instr[19:15];
  assign vm       = decoder_req_i.instr[25];
  assign is_vv    = (func3 == OPIVV) || (func3 == OPMVV);
  assign is_vi    = (func3 == OPIVI);
  assign is_opm   = (func3 == OPMVV) || (func3 == OPMVX);
  assign imm_sext = {{(ELEN-5){op_field[4]}}, op_field};
  assign imm_zext = elen_t'(op_field);

  always_comb begin
    vfu_req_o = '0;
    illegal_o = 1'b0;
    uimm      = 1'b0;

    vfu_req_o.ex_unit     = VFU;
    vfu_req_o.vd          = decoder_req_i.instr[11:7];
    vfu_req_o.use_vd      = 1'b1;
    vfu_req_o.vs2         = decoder_req_i.instr[24:20];
    vfu_req_o.use_vs2     = 1'b1;
    vfu_req_o.op_arith.vm = vm;
    vfu_req_o.op_sld.vm   = vm;

    // Second operand source
    case (func3)
      OPIVV, OPMVV: begin
        vfu_req_o.use_vs1 = 1'b1;
        vfu_req_o.vs1     = op_field;
      end
      OPIVI: vfu_req_o.rs1 = imm_sext;
      OPIVX, OPMVX: begin
        vfu_req_o.rs1 = decoder_req_i.rs1;
        illegal_o     = ~decoder_req_i.rs1_valid;
      end
      default: illegal_o = 1'b1;
    endcase

    if (is_opm) begin
      case (funct6)
        F6_VMUL: vfu_req_o.op = VMUL;
        F6_VMACC: begin
          vfu_req_o.op        = VMACC;
          vfu_req_o.vd_is_src = 1'b1;
        end
        // slide1up and slide1down
        F6_VSLIDEUP, F6_VSLIDEDOWN: begin
          vfu_req_o.op            = (funct6 == F6_VSLIDEUP) ? VSLIDEUP : VSLIDEDOWN;
          vfu_req_o.ex_unit       = SLD;
          vfu_req_o.op_sld.insert = 1'b1;
          illegal_o               = illegal_o | is_vv;
        end
        default: illegal_o = 1'b1;
      endcase
    end else begin
      case (funct6)
        F6_VADD:  vfu_req_o.op = VADD;
        F6_VSUB:  vfu_req_o.op = VSUB;
        F6_VRSUB: vfu_req_o.op = VRSUB;
        F6_VAND:  vfu_req_o.op = VAND;
        F6_VOR:   vfu_req_o.op = VOR;
        F6_VXOR:  vfu_req_o.op = VXOR;
        F6_VMIN:  vfu_req_o.op = VMIN;
        F6_VMINU: vfu_req_o.op = VMINU;
        F6_VMAX:  vfu_req_o.op = VMAX;
        F6_VMAXU: vfu_req_o.op = VMAXU;
        F6_VSLL, F6_VSRL, F6_VSRA: begin
          vfu_req_o.op = (funct6 == F6_VSLL) ? VSLL : (funct6 == F6_VSRL) ? VSRL : VSRA;
          uimm         = 1'b1;
        end
        // vmv is a slide by zero, vm clear would be vmerge
        F6_VMV: begin
          vfu_req_o.op            = VSLIDEUP;
          vfu_req_o.ex_unit       = SLD;
          vfu_req_o.op_sld.vmv    = 1'b1;
          vfu_req_o.op_sld.insert = ~is_vv;
          vfu_req_o.vs2           = vfu_req_o.vs1;
          vfu_req_o.use_vs2       = ~is_vi;
          illegal_o               = illegal_o | ~vm;
        end
        F6_VSLIDEUP, F6_VSLIDEDOWN: begin
          vfu_req_o.op      = (funct6 == F6_VSLIDEUP) ? VSLIDEUP : VSLIDEDOWN;
          vfu_req_o.ex_unit = SLD;
          uimm              = 1'b1;
          illegal_o         = illegal_o | is_vv;
        end
        default: illegal_o = 1'b1;
      endcase

      // Forms that the ISA leaves out
      if ((funct6 == F6_VSUB && is_vi) || (funct6 == F6_VRSUB && is_vv)) begin
        illegal_o = 1'b1;
      end
      if (is_vi && funct6 inside {F6_VMIN, F6_VMINU, F6_VMAX, F6_VMAXU}) begin
        illegal_o = 1'b1;
      end
      if (is_vi && uimm) begin
        vfu_req_o.rs1 = imm_zext;
      end
    end
  end

endmodule

/* spatz_lsu_decoder.sv */
`timescale 1ns/1ps

module spatz_lsu_decoder (
  input  spatz_decoder_pkg::decoder_req_t decoder_req_i,
  output spatz_decoder_pkg::spatz_req_t   lsu_req_o,
  output logic                            illegal_o
);
  import spatz_decoder_pkg::*;

  logic [1:0] mop;
  logic       strided;
  logic       is_load;

  assign mop     = decoder_req_i.instr[27:26];
  assign strided = (mop == MOP_STRIDED);
  assign is_load = (decoder_req_i.instr[6:0] == OPC_LOAD_FP);

  always_comb begin
    lsu_req_o = '0;
    illegal_o = 1'b0;

    lsu_req_o.ex_unit        = LSU;
    lsu_req_o.vd             = decoder_req_i.instr[11:7];
    lsu_req_o.use_vd         = 1'b1;
    // Stores read the data register
    lsu_req_o.vd_is_src      = ~is_load;
    lsu_req_o.op_mem.vm      = decoder_req_i.instr[25];
    lsu_req_o.op_mem.is_load = is_load;
    lsu_req_o.rs1            = decoder_req_i.rs1;

    // mew and width
    case ({decoder_req_i.instr[28], decoder_req_i.instr[14:12]})
      4'b0000: lsu_req_o.vtype.vsew = EW_8;
      4'b0101: lsu_req_o.vtype.vsew = EW_16;
      4'b0110: lsu_req_o.vtype.vsew = EW_32;
      default: illegal_o = 1'b1;
    endcase

    case (mop)
      MOP_UNIT: begin
        lsu_req_o.op = is_load ? VLE : VSE;
      end
      MOP_STRIDED: begin
        lsu_req_o.op  = is_load ? VLSE : VSSE;
        lsu_req_o.rs2 = decoder_req_i.rs2;
      end
      default: illegal_o = 1'b1;
    endcase

    // Base address, and the stride when strided
    if (!decoder_req_i.rs1_valid || (strided && !decoder_req_i.rs2_valid)) begin
      illegal_o = 1'b1;
    end
  end

endmodule

/* spatz_decoder_pkg.sv */
package spatz_decoder_pkg;

  localparam int unsigned ELEN = 32;

  typedef logic [ELEN-1:0] elen_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      vreg_t;
  typedef logic [3:0]      xintf_id_t;

  typedef enum logic [1:0] {
    EW_8  = 2'b00,
    EW_16 = 2'b01,
    EW_32 = 2'b10
  } vew_e;

  typedef enum logic [1:0] {
    CON,
    VFU,
    LSU,
    SLD
  } ex_unit_e;

  typedef enum logic [4:0] {
    VLE, VLSE, VSE, VSSE,
    VADD, VSUB, VRSUB,
    VAND, VOR, VXOR,
    VSLL, VSRL, VSRA,
    VMIN, VMINU, VMAX, VMAXU,
    VMUL, VMACC,
    VSLIDEUP, VSLIDEDOWN,
    VCSR, VCFG
  } op_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } opcodev_func3_e;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_OP_V     = 7'b1010111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  // OPI group
  localparam logic [5:0] F6_VADD       = 6'b000000;
  localparam logic [5:0] F6_VSUB       = 6'b000010;
  localparam logic [5:0] F6_VRSUB      = 6'b000011;
  localparam logic [5:0] F6_VAND       = 6'b001001;
  localparam logic [5:0] F6_VOR        = 6'b001010;
  localparam logic [5:0] F6_VXOR       = 6'b001011;
  localparam logic [5:0] F6_VSLL       = 6'b100101;
  localparam logic [5:0] F6_VSRL       = 6'b101000;
  localparam logic [5:0] F6_VSRA       = 6'b101001;
  localparam logic [5:0] F6_VMIN       = 6'b000101;
  localparam logic [5:0] F6_VMINU      = 6'b000100;
  localparam logic [5:0] F6_VMAX       = 6'b000111;
  localparam logic [5:0] F6_VMAXU      = 6'b000110;
  // OPM group, shares codes with the OPI group
  localparam logic [5:0] F6_VMUL       = 6'b100101;
  localparam logic [5:0] F6_VMACC      = 6'b101101;
  // Slides in both groups, slide1 forms are OPMVX
  localparam logic [5:0] F6_VSLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_VSLIDEDOWN = 6'b001111;
  localparam logic [5:0] F6_VMV        = 6'b010111;

  localparam logic [11:0] CSR_VSTART = 12'h008;
  localparam logic [11:0] CSR_VXSAT  = 12'h009;
  localparam logic [11:0] CSR_VXRM   = 12'h00A;
  localparam logic [11:0] CSR_VCSR   = 12'h00F;
  localparam logic [11:0] CSR_VL     = 12'hC20;
  localparam logic [11:0] CSR_VTYPE  = 12'hC21;
  localparam logic [11:0] CSR_VLENB  = 12'hC22;

  localparam logic [1:0] CSR_F3_RW = 2'b01;
  localparam logic [1:0] CSR_F3_RS = 2'b10;
  localparam logic [1:0] CSR_F3_RC = 2'b11;

  localparam logic [1:0] MOP_UNIT    = 2'b00;
  localparam logic [1:0] MOP_STRIDED = 2'b10;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       vill;
    vew_e       vsew;
    // vma, vta, upper vsew bit and vlmul
    logic [5:0] vlow;
  } vtype_t;

  typedef struct packed {
    logic vm;
    logic is_load;
  } op_mem_t;

  typedef struct packed {
    logic vm;
  } op_arith_t;

  typedef struct packed {
    logic vm;
    logic insert;
    logic vmv;
  } op_sld_t;

  typedef struct packed {
    logic keep_vl;
    logic write_vstart;
    logic set_vstart;
    logic clear_vstart;
    logic reset_vstart;
  } op_cfg_t;

  typedef struct packed {
    op_e         op;
    ex_unit_e    ex_unit;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    vreg_t       rd;
    logic        use_vd;
    logic        use_vs1;
    logic        use_vs2;
    logic        use_rd;
    logic        vd_is_src;
    elen_t       rs1;
    elen_t       rs2;
    vtype_t      vtype;
    logic [11:0] csr_addr;
    op_mem_t     op_mem;
    op_arith_t   op_arith;
    op_sld_t     op_sld;
    op_cfg_t     op_cfg;
    xintf_id_t   xintf_id;
  } spatz_req_t;

  typedef struct packed {
    instr_t    instr;
    elen_t     rs1;
    logic      rs1_valid;
    elen_t     rs2;
    logic      rs2_valid;
    xintf_id_t xintf_id;
  } decoder_req_t;

  typedef struct packed {
    spatz_req_t spatz_req;
    logic       instr_illegal;
  } decoder_rsp_t;

endpackage
